/* Makefile */
TOP = l2_amo_unit_tb
LOG = sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): l2_amo_unit.f design/*.sv design/*.svh sim/*.sv
	verilator --binary --timing --assert -f l2_amo_unit.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

lint:
	verilator --lint-only --timing -f l2_amo_unit.f --top-module l2_amo_unit

clean:
	rm -rf obj_dir $(LOG)

/* design/l2_amo_alu.sv */
/*
 * Atomic ALU. Computes the operation on the 8, 16, 32 and 64 bit
 * lanes at the request address and merges the chosen size into the line.
 */
`include "l2_amo_defs.svh"

module l2_amo_alu
    import l2_amo_msg_pkg::*, l2_amo_data_pkg::*;
(
    input  amo_alu_op_e                amo_alu_op,
    input  logic [`PHY_ADDR_WIDTH-1:0] address,
    input  msg_size_e                  data_size,
    input  l2_line_u                   memory_operand,
    input  l2_line_u                   cpu_operand,
    output l2_line_u                   amo_result
);

    localparam int NUM_SIZES = 4;

    logic [`L2_DATA_DATA_WIDTH-1:0] merged_line [NUM_SIZES];
    logic                           signed_cmp;
    logic                           is_sub;

    // Compares run the shared adder as a subtract
    assign signed_cmp = (amo_alu_op == MAX) || (amo_alu_op == MIN);
    assign is_sub     = signed_cmp || (amo_alu_op == MAXU) || (amo_alu_op == MINU);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One lane per access size
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar g = 0; g < NUM_SIZES; g++)
    begin : g_lane
        localparam int W = 8 << g;
        localparam logic [`L2_BYTE_OFFSET_WIDTH-1:0] OFF_MASK = 3'b111 << g;

        logic [`L2_DATA_DATA_WIDTH_LOG2-1:0] base;
        logic [W-1:0]                        op_a;
        logic [W-1:0]                        op_b;
        logic [W-1:0]                        res;
        logic [W:0]                          add_b;
        logic [W:0]                          sum;
        logic                                ext_a;
        logic                                ext_b;
        logic                                a_lt_b;
        logic [`L2_DATA_DATA_WIDTH-1:0]      merged;

        // Inverted dword bit puts offset 0..7 in the upper half
        assign base = {~address[`L2_DWORD_SEL_BIT],
                       address[`L2_BYTE_OFFSET_WIDTH-1:0] & OFF_MASK,
                       3'b000};

        assign op_a = memory_operand.flat[base +: W];
        assign op_b = cpu_operand.flat[base +: W];

        // Widened by one bit so the top bit is the compare result
        assign ext_a  = signed_cmp & op_a[W-1];
        assign ext_b  = signed_cmp & op_b[W-1];
        assign add_b  = {ext_b, op_b} ^ {(W+1){is_sub}};
        assign sum    = {ext_a, op_a} + add_b + {{W{1'b0}}, is_sub};
        assign a_lt_b = sum[W];

        always_comb
        begin
            case (amo_alu_op)
                NOP:       res = op_a;
                SWAP:      res = op_b;
                ADD:       res = sum[W-1:0];
                AND:       res = op_a & op_b;
                OR:        res = op_a | op_b;
                XOR:       res = op_a ^ op_b;
                MAX, MAXU: res = a_lt_b ? op_b : op_a;
                MIN, MINU: res = a_lt_b ? op_a : op_b;
                default:   res = op_a;
            endcase
        end

        always_comb
        begin
            merged             = memory_operand.flat;
            merged[base +: W]  = res;     // Only the addressed lane changes
        end

        assign merged_line[g] = merged;
    end

    // Size code doubles as lane number
    assign amo_result.flat = merged_line[data_size];

endmodule

/* design/l2_amo_data_pkg.sv */
/*
 * Data path types for the L2 atomic unit.
 * ALU opcode and the two views of a cache line.
 */
`include "l2_amo_defs.svh"

package l2_amo_data_pkg;

    typedef enum logic [`L2_AMO_ALU_OP_WIDTH-1:0] {
        NOP  = 4'd0,  // Line passes through unchanged
        SWAP = 4'd1,  // Result is the CPU operand
        ADD  = 4'd2,
        AND  = 4'd3,
        OR   = 4'd4,
        XOR  = 4'd5,
        MAX  = 4'd6,
        MAXU = 4'd7,
        MIN  = 4'd8,
        MINU = 4'd9
    } amo_alu_op_e;

    // Flat view for bit lanes, dword view for operand pick
    typedef union packed {
        logic [`L2_DATA_DATA_WIDTH-1:0]                               flat;
        logic [`L2_DATA_DATA_WIDTH/`L2_DWORD_WIDTH-1:0][`L2_DWORD_WIDTH-1:0] dword;
    } l2_line_u;

endpackage

/* design/l2_amo_decode.sv */
/*
 * Request decoder. Registers the request, flags misaligned
 * accesses and maps the request opcode onto an ALU operation.
 */
`include "l2_amo_defs.svh"

module l2_amo_decode
    import l2_amo_msg_pkg::*, l2_amo_data_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_val,
    input  msg_op_e                        req_op,
    input  logic [`PHY_ADDR_WIDTH-1:0]     req_addr,
    input  msg_size_e                      req_size,
    input  logic [`L2_DATA_DATA_WIDTH-1:0] req_data,
    output logic                           dec_val,
    output amo_alu_op_e                    dec_alu_op,
    output logic                           dec_wr_en,
    output logic                           dec_err,
    output logic [`PHY_ADDR_WIDTH-1:0]     dec_addr,
    output msg_size_e                      dec_size,
    output l2_line_u                       dec_cpu_operand
);

    amo_alu_op_e alu_op;
    logic        op_writes;
    logic        misaligned;

    // Low offset bits must be clear for the access size
    assign misaligned = |(req_addr[`L2_BYTE_OFFSET_WIDTH-1:0]
                          & ~(3'b111 << req_size));

    always_comb
    begin
        alu_op    = NOP;
        op_writes = 1'b1;
        case (req_op)
            LOAD:     op_writes = 1'b0;    // Read only
            STORE:    alu_op = SWAP;
            AMO_ADD:  alu_op = ADD;
            AMO_AND:  alu_op = AND;
            AMO_OR:   alu_op = OR;
            AMO_XOR:  alu_op = XOR;
            AMO_MAX:  alu_op = MAX;
            AMO_MAXU: alu_op = MAXU;
            AMO_MIN:  alu_op = MIN;
            AMO_MINU: alu_op = MINU;
            default:  op_writes = 1'b0;    // Unknown opcode acts as a load
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            dec_val   <= 1'b0;
            dec_wr_en <= 1'b0;
            dec_err   <= 1'b0;
        end
        else
        begin
            dec_val   <= req_val;
            dec_wr_en <= req_val & op_writes & ~misaligned;
            dec_err   <= req_val & misaligned;
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_val)
        begin
            dec_alu_op           <= alu_op;
            dec_addr             <= req_addr;
            dec_size             <= req_size;
            dec_cpu_operand.flat <= req_data;
        end
    end

endmodule

/* design/l2_amo_defs.svh */
/*
 * L2 atomic unit shared widths.
 * Address, line and lane placement constants used across the design.
 */
`ifndef L2_AMO_DEFS_SVH
`define L2_AMO_DEFS_SVH

`define PHY_ADDR_WIDTH           16  // Byte address
`define L2_DATA_DATA_WIDTH       128 // One cache line
`define L2_DATA_DATA_WIDTH_LOG2  7
`define L2_NUM_LINES             16
`define L2_INDEX_WIDTH           4
`define L2_INDEX_LSB             4   // Index sits in address bits 7:4

// Lane placement inside a line
`define L2_DWORD_WIDTH           64
`define L2_DWORD_SEL_BIT         3   // Clear selects line bits 127:64
`define L2_BYTE_OFFSET_WIDTH     3   // Byte within a dword

// Encoded field widths
`define MSG_OP_WIDTH             4
`define MSG_DATA_SIZE_WIDTH      2
`define L2_AMO_ALU_OP_WIDTH      4

`endif

/* design/l2_amo_exec.sv */
/*
 * Execute stage. Runs the ALU on the read line, drives the
 * write-back and registers the response.
 */
`include "l2_amo_defs.svh"

module l2_amo_exec
    import l2_amo_msg_pkg::*, l2_amo_data_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       dec_val,
    input  amo_alu_op_e                dec_alu_op,
    input  logic                       dec_wr_en,
    input  logic                       dec_err,
    input  logic [`PHY_ADDR_WIDTH-1:0] dec_addr,
    input  msg_size_e                  dec_size,
    input  l2_line_u                   dec_cpu_operand,
    input  l2_line_u                   rd_line,
    output logic                       wr_en,
    output logic [`L2_INDEX_WIDTH-1:0] wr_index,
    output l2_line_u                   wr_line,
    output logic                       resp_val,
    output logic                       resp_err,
    output logic [`L2_DWORD_WIDTH-1:0] resp_data
);

    logic [`L2_DWORD_WIDTH-1:0] old_dword;
    logic [`L2_DWORD_WIDTH-1:0] old_shifted;
    logic [`L2_DWORD_WIDTH-1:0] old_operand;

    l2_amo_alu u_alu (
        .amo_alu_op     (dec_alu_op),
        .address        (dec_addr),
        .data_size      (dec_size),
        .memory_operand (rd_line),
        .cpu_operand    (dec_cpu_operand),
        .amo_result     (wr_line)
    );

    assign wr_en    = dec_val && dec_wr_en && !dec_err;
    assign wr_index = dec_addr[`L2_INDEX_LSB +: `L2_INDEX_WIDTH];

    // Old operand moved down to bit 0
    assign old_dword   = rd_line.dword[~dec_addr[`L2_DWORD_SEL_BIT]];
    assign old_shifted = old_dword >> {dec_addr[`L2_BYTE_OFFSET_WIDTH-1:0], 3'b000};

    always_comb
    begin
        case (dec_size)
            SIZE_1B: old_operand = {56'd0, old_shifted[7:0]};
            SIZE_2B: old_operand = {48'd0, old_shifted[15:0]};
            SIZE_4B: old_operand = {32'd0, old_shifted[31:0]};
            default: old_operand = old_shifted;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            resp_val <= 1'b0;
            resp_err <= 1'b0;
        end
        else
        begin
            resp_val <= dec_val;
            resp_err <= dec_val & dec_err;
        end
    end

    always_ff @(posedge clk)
    begin
        if (dec_val)
        begin
            resp_data <= dec_err ? '0 : old_operand;   // Nothing returned on error
        end
    end

endmodule

/* design/l2_amo_line_store.sv */
/*
 * Direct-indexed line store. Registered read with forwarding
 * of a same-cycle write to the same index.
 */
`include "l2_amo_defs.svh"

module l2_amo_line_store
    import l2_amo_data_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rd_val,
    input  logic [`L2_INDEX_WIDTH-1:0] rd_index,
    input  logic                       wr_en,
    input  logic [`L2_INDEX_WIDTH-1:0] wr_index,
    input  l2_line_u                   wr_line,
    output l2_line_u                   rd_line
);

    l2_line_u lines [`L2_NUM_LINES];
    logic     fwd_hit;

    // Write lands on the same edge that samples the read
    assign fwd_hit = wr_en && (wr_index == rd_index);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Storage array
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `L2_NUM_LINES; i++)
            begin
                lines[i] <= '0;          // Store starts all zero
            end
        end
        else if (wr_en)
        begin
            lines[wr_index] <= wr_line;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read port
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk)
    begin
        if (rd_val)
        begin
            if (fwd_hit)
            begin
                rd_line <= wr_line;      // Newer data than the array
            end
            else
            begin
                rd_line <= lines[rd_index];
            end
        end
    end

endmodule

/* design/l2_amo_msg_pkg.sv */
/*
 * Request message types for the L2 atomic unit.
 * Opcode and access size as seen on the request port.
 */
`include "l2_amo_defs.svh"

package l2_amo_msg_pkg;

    // Request opcode
    typedef enum logic [`MSG_OP_WIDTH-1:0] {
        LOAD     = 4'd0,
        STORE    = 4'd1,
        AMO_ADD  = 4'd2,
        AMO_AND  = 4'd3,
        AMO_OR   = 4'd4,
        AMO_XOR  = 4'd5,
        AMO_MAX  = 4'd6,  // Signed
        AMO_MAXU = 4'd7,
        AMO_MIN  = 4'd8,  // Signed
        AMO_MINU = 4'd9
    } msg_op_e;

    // Access size as log2 of the byte count
    typedef enum logic [`MSG_DATA_SIZE_WIDTH-1:0] {
        SIZE_1B = 2'd0,
        SIZE_2B = 2'd1,
        SIZE_4B = 2'd2,
        SIZE_8B = 2'd3
    } msg_size_e;

endpackage

/* design/l2_amo_unit.sv */
/*
 * L2 atomic unit top level. Decoder and line store in the
 * request cycle, execute stage in the cycle after.
 */
`include "l2_amo_defs.svh"

module l2_amo_unit
    import l2_amo_msg_pkg::*, l2_amo_data_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           req_val,
    input  msg_op_e                        req_op,
    input  logic [`PHY_ADDR_WIDTH-1:0]     req_addr,
    input  msg_size_e                      req_size,
    input  logic [`L2_DATA_DATA_WIDTH-1:0] req_data,
    output logic                           resp_val,
    output logic                           resp_err,
    output logic [`L2_DWORD_WIDTH-1:0]     resp_data
);

    logic                       dec_val;
    amo_alu_op_e                dec_alu_op;
    logic                       dec_wr_en;
    logic                       dec_err;
    logic [`PHY_ADDR_WIDTH-1:0] dec_addr;
    msg_size_e                  dec_size;
    l2_line_u                   dec_cpu_operand;
    l2_line_u                   rd_line;
    logic                       wr_en;
    logic [`L2_INDEX_WIDTH-1:0] wr_index;
    l2_line_u                   wr_line;

    l2_amo_decode u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .req_val         (req_val),
        .req_op          (req_op),
        .req_addr        (req_addr),
        .req_size        (req_size),
        .req_data        (req_data),
        .dec_val         (dec_val),
        .dec_alu_op      (dec_alu_op),
        .dec_wr_en       (dec_wr_en),
        .dec_err         (dec_err),
        .dec_addr        (dec_addr),
        .dec_size        (dec_size),
        .dec_cpu_operand (dec_cpu_operand)
    );

    // Read issued straight from the request
    l2_amo_line_store u_line_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_val   (req_val),
        .rd_index (req_addr[`L2_INDEX_LSB +: `L2_INDEX_WIDTH]),
        .wr_en    (wr_en),
        .wr_index (wr_index),
        .wr_line  (wr_line),
        .rd_line  (rd_line)
    );

    l2_amo_exec u_exec (
        .clk             (clk),
        .rst_n           (rst_n),
        .dec_val         (dec_val),
        .dec_alu_op      (dec_alu_op),
        .dec_wr_en       (dec_wr_en),
        .dec_err         (dec_err),
        .dec_addr        (dec_addr),
        .dec_size        (dec_size),
        .dec_cpu_operand (dec_cpu_operand),
        .rd_line         (rd_line),
        .wr_en           (wr_en),
        .wr_index        (wr_index),
        .wr_line         (wr_line),
        .resp_val        (resp_val),
        .resp_err        (resp_err),
        .resp_data       (resp_data)
    );

endmodule

/* l2_amo_unit.f */
+incdir+design
design/l2_amo_msg_pkg.sv
design/l2_amo_data_pkg.sv
design/l2_amo_alu.sv
design/l2_amo_decode.sv
design/l2_amo_line_store.sv
design/l2_amo_exec.sv
design/l2_amo_unit.sv
sim/l2_amo_unit_tb.sv

/* sim/l2_amo_unit_tb.sv */
/*
 * Testbench for the L2 atomic unit. A byte memory model predicts each
 * response, and immediate assertions compare it at the falling edge.
 */
`include "l2_amo_defs.svh"

module l2_amo_unit_tb
    import l2_amo_msg_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_BURSTS   = 8;
    localparam int BURST_LEN    = 6;
    localparam int NUM_MISALIGN = 12;
    localparam int TOTAL_REQS   = 4 * 6 + NUM_RANDOM * 2 + NUM_BURSTS * (BURST_LEN + 2)
                                  + NUM_MISALIGN * 2;

    logic                           clk;
    logic                           rst_n;
    logic                           req_val;
    msg_op_e                        req_op;
    logic [`PHY_ADDR_WIDTH-1:0]     req_addr;
    msg_size_e                      req_size;
    logic [`L2_DATA_DATA_WIDTH-1:0] req_data;
    logic                           resp_val;
    logic                           resp_err;
    logic [`L2_DWORD_WIDTH-1:0]     resp_data;

    logic [7:0]  mem [256];           // One byte per address across all 16 lines
    time         exp_due [$];         // Edge that registers the response
    logic        exp_err [$];
    logic [63:0] exp_data [$];
    int          seed = 98824;
    int          errors = 0;
    int          checked = 0;

    l2_amo_unit u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_val   (req_val),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_size  (req_size),
        .req_data  (req_data),
        .resp_val  (resp_val),
        .resp_err  (resp_err),
        .resp_data (resp_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [63:0] atomic_result(input msg_op_e op, input int nbytes,
                                                  input logic [63:0] a, input logic [63:0] b);
        logic [63:0]        mask;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        int                 sh;
        sh   = 64 - 8 * nbytes;
        mask = {64{1'b1}} >> sh;
        sa   = $signed(a << sh) >>> sh;   // Sign taken from the operand's top byte
        sb   = $signed(b << sh) >>> sh;
        case (op)
            AMO_ADD:  return (a + b) & mask;
            AMO_AND:  return a & b;
            AMO_OR:   return a | b;
            AMO_XOR:  return a ^ b;
            AMO_MAX:  return (sa > sb) ? a : b;
            AMO_MAXU: return (a > b) ? a : b;
            AMO_MIN:  return (sa < sb) ? a : b;
            AMO_MINU: return (a < b) ? a : b;
            default:  return b;           // Store
        endcase
    endfunction

    function automatic logic [63:0] read_model(input logic [15:0] addr, input int nbytes);
        logic [63:0] val;
        val = '0;
        for (int i = 0; i < nbytes; i++)
        begin
            val[8*i +: 8] = mem[addr[7:0] + 8'(i)];
        end
        return val;
    endfunction

    function automatic void write_model(input logic [15:0] addr, input int nbytes,
                                        input logic [63:0] val);
        for (int i = 0; i < nbytes; i++)
        begin
            mem[addr[7:0] + 8'(i)] = val[8*i +: 8];
        end
    endfunction

    // Address bit 3 clear selects the upper dword
    function automatic logic [127:0] place_operand(input logic [15:0] addr, input int nbytes,
                                                   input logic [63:0] operand);
        logic [127:0] line;
        logic [2:0]   k;
        line = {$random(seed), $random(seed), $random(seed), $random(seed)};
        for (int i = 0; i < nbytes; i++)
        begin
            k = addr[2:0] + 3'(i);
            line[(addr[3] ? 0 : 64) + 8 * int'(k) +: 8] = operand[8*i +: 8];
        end
        return line;
    endfunction

    function automatic logic [15:0] align_addr(input logic [15:0] addr, input msg_size_e size);
        return addr & ~((16'd1 << size) - 16'd1);
    endfunction

    function automatic logic [63:0] random_dword();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic msg_op_e random_amo();
        logic [2:0] pick;
        pick = 3'($random(seed));
        return msg_op_e'(AMO_ADD + {1'b0, pick});
    endfunction

    // Queues the expected response, updates the model, drives one request
    task automatic issue(input msg_op_e op, input logic [15:0] addr, input msg_size_e size,
                         input logic [63:0] operand);
        int          nbytes;
        logic [63:0] mask;
        logic [63:0] old_val;
        logic        bad;
        nbytes  = 1 << size;
        mask    = {64{1'b1}} >> (64 - 8 * nbytes);
        bad     = (int'(addr[2:0]) % nbytes) != 0;
        old_val = read_model(addr, nbytes);
        exp_due.push_back($time + 2 * CLK_PERIOD);
        exp_err.push_back(bad);
        exp_data.push_back(bad ? 64'd0 : old_val);
        if (!bad && op != LOAD)
        begin
            write_model(addr, nbytes, atomic_result(op, nbytes, old_val, operand & mask));
        end
        req_val  <= 1'b1;
        req_op   <= op;
        req_addr <= addr;
        req_size <= size;
        req_data <= place_operand(addr, nbytes, operand & mask);
        @(posedge clk);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Response checker
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(negedge clk)
    begin
        if (exp_due.size() > 0 && exp_due[0] == $time - CLK_PERIOD / 2)
        begin
            checked++;
            assert (resp_val === 1'b1 && resp_err === exp_err[0] && resp_data === exp_data[0])
            else
            begin
                errors++;
                $display("[ERROR] %0t: got val %b err %b data %h, expected err %b data %h",
                         $time, resp_val, resp_err, resp_data, exp_err[0], exp_data[0]);
            end
            void'(exp_due.pop_front());
            void'(exp_err.pop_front());
            void'(exp_data.pop_front());
        end
        else
        begin
            assert (resp_val === 1'b0)
            else
            begin
                errors++;
                $display("[ERROR] %0t: resp_val high with no response due", $time);
            end
        end
    end

    initial
    begin
        #(TOTAL_REQS * CLK_PERIOD * 4 + RESET_CYCLES * CLK_PERIOD);
        $display("Timeout: responses still outstanding, %0d errors so far", errors);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial
    begin
        logic [15:0] addr;
        logic [15:0] base;
        msg_size_e   size;
        req_val  = 1'b0;
        req_op   = LOAD;
        req_addr = '0;
        req_size = SIZE_1B;
        req_data = '0;
        rst_n    = 1'b0;
        mem      = '{default: 8'h00};     // Store resets to zero
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        // Store and load per size with both dwords prefilled to catch stray writes
        for (int s = 0; s < 4; s++)
        begin
            size = msg_size_e'(2'(s));
            base = 16'h0040 + 16'(s * 16);
            issue(STORE, base, SIZE_8B, random_dword());
            issue(STORE, base + 16'd8, SIZE_8B, random_dword());
            issue(STORE, align_addr(base + 16'd13, size), size, random_dword());
            issue(LOAD, align_addr(base + 16'd13, size), size, 64'd0);
            issue(LOAD, base, SIZE_8B, 64'd0);
            issue(LOAD, base + 16'd8, SIZE_8B, 64'd0);
        end

        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            size = msg_size_e'(2'($random(seed)));
            addr = align_addr(16'($random(seed)), size);
            issue(random_amo(), addr, size, random_dword());
            issue(LOAD, addr, size, 64'd0);
        end

        // Same line on consecutive cycles to exercise forwarding
        for (int b = 0; b < NUM_BURSTS; b++)
        begin
            base = 16'($random(seed)) & 16'hfff0;
            for (int j = 0; j < BURST_LEN; j++)
            begin
                size = msg_size_e'(2'($random(seed)));
                addr = align_addr(base | 16'($random(seed) & 15), size);
                issue(random_amo(), addr, size, random_dword());
            end
            issue(LOAD, base, SIZE_8B, 64'd0);
            issue(LOAD, base | 16'd8, SIZE_8B, 64'd0);
        end

        // Odd offset is misaligned for every size above one byte
        for (int i = 0; i < NUM_MISALIGN; i++)
        begin
            size = msg_size_e'(2'(1 + i % 3));
            addr = align_addr(16'($random(seed)), size) | 16'd1;
            issue((i % 4 == 0) ? STORE : random_amo(), addr, size, random_dword());
            issue(LOAD, addr & 16'hfff8, SIZE_8B, 64'd0);
        end

        req_val <= 1'b0;
        while (exp_due.size() > 0)
        begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        $display("Run complete: %0d responses checked, %0d errors", checked, errors);
        if (errors == 0)
        begin
            $display("SIMULATION PASSED");
        end
        else
        begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
